/* axi_bus.f */
hw/axi_bus_pkg.sv
hw/addr_decoder.sv
hw/axi_read_path.sv
hw/axi_write_path.sv
hw/axi_bus.sv
dv/axi_bus_checker.sv
dv/tb_axi_bus.sv

/* dv/axi_bus_checker.sv */
`timescale 1ns/10ps

module axi_bus_checker #(
	parameter int master_num = 2,
	parameter int slave_num  = 3
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	input  axi_bus_pkg::ax_t      m_ar [master_num],
	input  logic [master_num-1:0] m_arvalid,
	input  logic [master_num-1:0] m_arready,
	input  axi_bus_pkg::r_t       m_r [master_num],
	input  logic [master_num-1:0] m_rvalid,
	input  logic [master_num-1:0] m_rready,
	input  axi_bus_pkg::ax_t      m_aw [master_num],
	input  logic [master_num-1:0] m_awvalid,
	input  logic [master_num-1:0] m_awready,
	input  logic [master_num-1:0] m_wready,
	input  axi_bus_pkg::b_t       m_b [master_num],
	input  logic [master_num-1:0] m_bvalid,
	input  logic [master_num-1:0] m_bready,
	input  axi_bus_pkg::ax_t      s_ar [slave_num],
	input  logic [slave_num-1:0]  s_arvalid,
	input  logic [slave_num-1:0]  s_arready,
	input  logic [slave_num-1:0]  s_rready,
	input  axi_bus_pkg::ax_t      s_aw [slave_num],
	input  logic [slave_num-1:0]  s_awvalid,
	input  logic [slave_num-1:0]  s_awready,
	input  axi_bus_pkg::w_t       s_w [slave_num],
	input  logic [slave_num-1:0]  s_wvalid,
	input  logic [slave_num-1:0]  s_wready,
	input  logic [slave_num-1:0]  s_bready,
	input  logic [31:0]           rexp_seed [master_num],
	input  logic [7:0]            rexp_len [master_num],
	input  logic [3:0]            rexp_id [master_num],
	input  logic [31:0]           wexp_seed [master_num],
	input  logic [7:0]            wexp_len [master_num],
	input  logic [3:0]            wexp_id [master_num],
	output int                    errors
);

	logic rd_open = 1'b0;
	logic wr_open = 1'b0;
	int   rd_master;
	int   rd_beat;
	int   wr_master;
	int   wr_slave;
	int   wr_beat;

	initial errors = 0;

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// request fields reach the slave unchanged
	task automatic check_ax(input string ch, input axi_bus_pkg::ax_t exp,
	                        input axi_bus_pkg::ax_t act);
		check_val({ch, ".id"}, 32'(exp.id), 32'(act.id));
		check_val({ch, ".addr"}, exp.addr, act.addr);
		check_val({ch, ".len"}, 32'(exp.len), 32'(act.len));
		check_val({ch, ".size"}, 32'(exp.size), 32'(act.size));
		check_val({ch, ".burst"}, 32'(exp.burst), 32'(act.burst));
	endtask

	task automatic fault(input string msg);
		$display("at %0t: %s", $time, msg);
		errors++;
	endtask

	// sampled mid-cycle, away from the clock edge
	always @(negedge ACLK) begin
		if (!rd_open && m_arvalid == '0 && {m_arready, m_rvalid, s_arvalid, s_rready} !== '0)
			fault("read path drives a valid or ready while idle");
		if (!wr_open && m_awvalid == '0 &&
		    {m_awready, m_wready, m_bvalid, s_awvalid, s_wvalid, s_bready} !== '0)
			fault("write path drives a valid or ready while idle");

		for (int i = 0; i < master_num; i++) begin
			if (m_arvalid[i] && m_arready[i]) begin
				rd_master = i;
				rd_open   = 1'b1;
				rd_beat   = 0;
			end
		end
		for (int j = 0; j < slave_num; j++) begin
			if (s_arvalid[j] && ($countones(s_arvalid) != 1 || s_ar[j].addr[31:28] != 4'(j)))
				fault("read address offered to a slave that does not own it");
			if (s_arvalid[j] && s_arready[j])
				check_ax("s_ar", m_ar[rd_master], s_ar[j]);
		end
		for (int i = 0; i < master_num; i++) begin
			if (m_rvalid[i] && m_rready[i]) begin
				if (!rd_open || i != rd_master)
					fault("read data reached a master with no read in flight");
				check_val("m_r.data", rexp_seed[i] + 32'(rd_beat), m_r[i].data);
				check_val("m_r.id", 32'(rexp_id[i]), 32'(m_r[i].id));
				check_val("m_r.last", 32'(rd_beat == int'(rexp_len[i])), 32'(m_r[i].last));
				if (m_r[i].last)
					rd_open = 1'b0;
				rd_beat++;
			end
		end

		for (int i = 0; i < master_num; i++) begin
			if (m_awvalid[i] && m_awready[i]) begin
				if (wr_open)
					fault("write address accepted while another write is in flight");
				for (int k = 0; k < i; k++) begin
					if (m_awvalid[k])
						fault("lower index master passed over by the write arbiter");
				end
				wr_master = i;
				wr_open   = 1'b1;
				wr_beat   = 0;
			end
		end
		for (int j = 0; j < slave_num; j++) begin
			if (s_awvalid[j]) begin
				if ($countones(s_awvalid) != 1 || s_aw[j].addr[31:28] != 4'(j))
					fault("write address offered to a slave that does not own it");
				if (s_awready[j]) begin
					wr_slave = j;
					check_ax("s_aw", m_aw[wr_master], s_aw[j]);
				end
			end
		end
		for (int j = 0; j < slave_num; j++) begin
			if (s_wvalid[j] && j != wr_slave)
				fault("write data offered to a slave other than the addressed one");
			if (s_wvalid[j] && s_wready[j]) begin
				check_val("s_w.data", wexp_seed[wr_master] + 32'(wr_beat), s_w[j].data);
				check_val("s_w.strb", 32'hf, 32'(s_w[j].strb));
				check_val("s_w.last", 32'(wr_beat == int'(wexp_len[wr_master])),
				          32'(s_w[j].last));
				wr_beat++;
			end
		end
		for (int i = 0; i < master_num; i++) begin
			if (m_bvalid[i] && m_bready[i]) begin
				if (!wr_open || i != wr_master)
					fault("write response reached a master with no write in flight");
				check_val("m_b.id", 32'(wexp_id[i]), 32'(m_b[i].id));
				wr_open = 1'b0;
			end
		end

		if (!ARESETn) begin
			rd_open = 1'b0;
			wr_open = 1'b0;
		end
	end

endmodule

/* dv/axi_bus_input.txt */
// op master addr len seed id ; op 1 write, 0 read, 2 both masters write, ff end
// op 2 master 1 uses addr+40 and seed+100
1 0 00000010 3 a0000000 1
0 1 00000010 3 a0000000 2
1 0 10000020 7 b1000000 3
0 1 10000020 7 b1000000 4
1 1 20000000 0 c2000000 5
0 0 20000000 0 c2000000 6
2 0 20000080 3 d3000000 7
0 1 20000080 3 d3000000 8
0 0 200000c0 3 d3000100 9
1 1 00000100 f e4000000 a
0 0 00000100 f e4000000 b
ff 0 0 0 0 0

/* dv/tb_axi_bus.sv */
`timescale 1ns/10ps

module tb_axi_bus;

	localparam int master_num = 2;
	localparam int slave_num  = 3;
	localparam int tmo_cycles = 300;

	logic ACLK;
	logic ARESETn;

	axi_bus_pkg::ax_t m_ar [master_num];
	axi_bus_pkg::ax_t m_aw [master_num];
	axi_bus_pkg::r_t  m_r [master_num];
	axi_bus_pkg::w_t  m_w [master_num];
	axi_bus_pkg::b_t  m_b [master_num];
	logic [master_num-1:0] m_arvalid, m_arready, m_rvalid, m_rready;
	logic [master_num-1:0] m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;

	axi_bus_pkg::ax_t s_ar [slave_num];
	axi_bus_pkg::ax_t s_aw [slave_num];
	axi_bus_pkg::r_t  s_r [slave_num];
	axi_bus_pkg::w_t  s_w [slave_num];
	axi_bus_pkg::b_t  s_b [slave_num];
	logic [slave_num-1:0] s_arvalid, s_arready, s_rvalid, s_rready;
	logic [slave_num-1:0] s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;

	logic [31:0] rexp_seed [master_num];
	logic [7:0]  rexp_len [master_num];
	logic [3:0]  rexp_id [master_num];
	logic [31:0] wexp_seed [master_num];
	logic [7:0]  wexp_len [master_num];
	logic [3:0]  wexp_id [master_num];
	int          err_count;
	int          timeouts = 0;

	logic [31:0] lfsr = 32'h4b64_3127;
	logic [18:0] rnd = '0;
	logic [31:0] stim [0:71];

	// slave memories and their burst state
	logic [31:0] mem [slave_num][256];
	logic [7:0]  rd_base [slave_num];
	logic [7:0]  rd_beat [slave_num];
	logic [7:0]  rd_len [slave_num];
	logic [3:0]  rd_id [slave_num];
	logic        rd_busy [slave_num];
	logic [1:0]  wr_ph [slave_num];
	logic [7:0]  wr_idx [slave_num];
	logic [3:0]  wr_id [slave_num];
	logic [slave_num-1:0] ar_hs, r_hs, aw_hs, w_hs, b_hs;
	axi_bus_pkg::ax_t ar_cap [slave_num];
	axi_bus_pkg::ax_t aw_cap [slave_num];
	axi_bus_pkg::w_t  w_cap [slave_num];

	axi_bus #(
		.master_num(master_num),
		.slave_num (slave_num)
	) DUT (.*);

	axi_bus_checker #(
		.master_num(master_num),
		.slave_num (slave_num)
	) u_chk (
		.errors(err_count),
		.*
	);

	initial begin
		ACLK = 1'b0;
		forever #4 ACLK = ~ACLK;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step for each stall bit of the cycle
	always @(posedge ACLK) begin
		for (int k = 0; k < 19; k++) begin
			rnd[k] = lfsr[0];
			lfsr   = lfsr_next(lfsr);
		end
	end

	initial begin
		m_rready = '0;
		m_bready = '0;
		forever begin
			@(posedge ACLK);
			#1;
			m_rready = ARESETn ? rnd[16:15] : '0;
			m_bready = ARESETn ? rnd[18:17] : '0;
		end
	end

	initial begin
		for (int j = 0; j < slave_num; j++) begin
			s_r[j]     = '0;
			s_b[j]     = '0;
			rd_busy[j] = 1'b0;
			wr_ph[j]   = 2'd0;
		end
		{s_arready, s_rvalid, s_awready, s_wready, s_bvalid} = '0;
		forever begin
			@(posedge ACLK);
			for (int j = 0; j < slave_num; j++) begin // values before the DUT flops move
				ar_hs[j]  = s_arvalid[j] && s_arready[j];
				r_hs[j]   = s_rvalid[j] && s_rready[j];
				aw_hs[j]  = s_awvalid[j] && s_awready[j];
				w_hs[j]   = s_wvalid[j] && s_wready[j];
				b_hs[j]   = s_bvalid[j] && s_bready[j];
				ar_cap[j] = s_ar[j];
				aw_cap[j] = s_aw[j];
				w_cap[j]  = s_w[j];
			end
			#1;
			for (int j = 0; j < slave_num; j++) begin
				if (!ARESETn) begin
					rd_busy[j] = 1'b0;
					wr_ph[j]   = 2'd0;
				end else begin
					if (ar_hs[j]) begin
						rd_busy[j] = 1'b1;
						rd_base[j] = ar_cap[j].addr[9:2];
						rd_len[j]  = ar_cap[j].len;
						rd_id[j]   = ar_cap[j].id;
						rd_beat[j] = '0;
					end
					if (r_hs[j]) begin
						if (s_r[j].last)
							rd_busy[j] = 1'b0;
						rd_beat[j]  = rd_beat[j] + 8'd1;
						s_rvalid[j] = 1'b0;
					end
					if (wr_ph[j] == 2'd0 && aw_hs[j]) begin
						wr_ph[j]  = 2'd1;
						wr_idx[j] = aw_cap[j].addr[9:2];
						wr_id[j]  = aw_cap[j].id;
					end else if (wr_ph[j] == 2'd1 && w_hs[j]) begin
						mem[j][wr_idx[j]] = w_cap[j].data;
						wr_idx[j] = wr_idx[j] + 8'd1;
						if (w_cap[j].last)
							wr_ph[j] = 2'd2;
					end else if (wr_ph[j] == 2'd2 && b_hs[j]) begin
						wr_ph[j] = 2'd0;
					end
				end
				s_arready[j] = ARESETn && !rd_busy[j] && rnd[5*j];
				s_rvalid[j]  = rd_busy[j] && (s_rvalid[j] || rnd[5*j+1]); // held once raised
				if (s_rvalid[j])
					s_r[j] = '{id: rd_id[j], data: mem[j][rd_base[j] + rd_beat[j]],
					           resp: 2'd0, last: (rd_beat[j] == rd_len[j])};
				else
					s_r[j] = '0;
				s_awready[j] = ARESETn && wr_ph[j] == 2'd0 && rnd[5*j+2];
				s_wready[j]  = wr_ph[j] == 2'd1 && rnd[5*j+3];
				s_bvalid[j]  = wr_ph[j] == 2'd2 && (s_bvalid[j] || rnd[5*j+4]);
				if (s_bvalid[j])
					s_b[j] = '{id: wr_id[j], resp: 2'd0};
				else
					s_b[j] = '0;
			end
		end
	end

	task automatic wait_handshake(input int m, input int kind, output logic ok);
		int   n;
		logic hit;
		string ch;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < tmo_cycles) begin
			@(posedge ACLK);
			case (kind)
				0: hit = m_arvalid[m] && m_arready[m];
				1: hit = m_rvalid[m] && m_rready[m];
				2: hit = m_awvalid[m] && m_awready[m];
				3: hit = m_wvalid[m] && m_wready[m];
				default: hit = m_bvalid[m] && m_bready[m];
			endcase
			ok = hit;
			n++;
		end
		#1;
		if (!ok) begin
			ch = (kind == 0) ? "AR" : (kind == 1) ? "R" : (kind == 2) ? "AW" :
			     (kind == 3) ? "W" : "B";
			$display("timeout: master %0d saw no %s handshake in %0d cycles", m, ch, n);
			timeouts++;
		end
	endtask

	task automatic write_burst(input int m, input logic [31:0] addr, input logic [7:0] len,
	                           input logic [31:0] seed, input logic [3:0] id);
		logic ok;
		wexp_seed[m] = seed;
		wexp_len[m]  = len;
		wexp_id[m]   = id;
		m_aw[m] = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'd1};
		m_awvalid[m] = 1'b1;
		wait_handshake(m, 2, ok);
		m_awvalid[m] = 1'b0;
		m_aw[m]      = '0;
		if (!ok)
			return;
		for (int beat = 0; beat <= int'(len); beat++) begin
			m_w[m] = '{data: seed + 32'(beat), strb: 4'hf, last: (beat == int'(len))};
			m_wvalid[m] = 1'b1;
			wait_handshake(m, 3, ok);
			if (!ok)
				break;
		end
		m_wvalid[m] = 1'b0;
		m_w[m]      = '0;
		if (ok)
			wait_handshake(m, 4, ok);
	endtask

	task automatic read_burst(input int m, input logic [31:0] addr, input logic [7:0] len,
	                          input logic [31:0] seed, input logic [3:0] id);
		logic ok;
		rexp_seed[m] = seed;
		rexp_len[m]  = len;
		rexp_id[m]   = id;
		m_ar[m] = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'd1};
		m_arvalid[m] = 1'b1;
		wait_handshake(m, 0, ok);
		m_arvalid[m] = 1'b0;
		m_ar[m]      = '0;
		for (int beat = 0; ok && beat <= int'(len); beat++)
			wait_handshake(m, 1, ok);
	endtask

	initial begin
		int b;
		int row;
		for (int i = 0; i < master_num; i++) begin
			m_ar[i] = '0;
			m_aw[i] = '0;
			m_w[i]  = '0;
			{rexp_seed[i], rexp_len[i], rexp_id[i]} = '0;
			{wexp_seed[i], wexp_len[i], wexp_id[i]} = '0;
		end
		{m_arvalid, m_awvalid, m_wvalid} = '0;
		ARESETn = 1'b0;
		$readmemh("dv/axi_bus_input.txt", stim);
		repeat (4) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		row = 0;
		while (row < 12 && timeouts == 0 && stim[row*6] !== 32'hff) begin
			b = row * 6;
			case (stim[b][7:0])
				8'h00: read_burst(int'(stim[b+1]), stim[b+2], stim[b+3][7:0], stim[b+4],
				                  stim[b+5][3:0]);
				8'h01: write_burst(int'(stim[b+1]), stim[b+2], stim[b+3][7:0], stim[b+4],
				                   stim[b+5][3:0]);
				default: fork // both masters request in the same cycle
					write_burst(0, stim[b+2], stim[b+3][7:0], stim[b+4], stim[b+5][3:0]);
					write_burst(1, stim[b+2] + 32'h40, stim[b+3][7:0], stim[b+4] + 32'h100,
					            stim[b+5][3:0]);
				join
			endcase
			row++;
		end
		repeat (4) @(posedge ACLK);
		$display("errors: %0d check, %0d timeout, %0d lines run", err_count, timeouts, row);
		if (err_count == 0 && timeouts == 0 && row == 11)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* hw/addr_decoder.sv */
`timescale 1ns/10ps

module addr_decoder #(
	parameter int slave_num = 3
) (
	input  logic [axi_bus_pkg::addr_w-1:0] addr,
	output logic [slave_num-1:0]           sel
);

	localparam int field_w = axi_bus_pkg::addr_w - axi_bus_pkg::slave_sel_lsb;

	logic [field_w-1:0] field;

	assign field = addr[axi_bus_pkg::addr_w-1:axi_bus_pkg::slave_sel_lsb];

	// one compare per slave; an unmapped field matches none of them
	genvar j;
	for (j = 0; j < slave_num; j++) begin : g_sel
		assign sel[j] = (field == field_w'(j));
	end

endmodule

/* hw/axi_bus.sv */
`timescale 1ns/10ps

module axi_bus #(
	parameter int master_num = 2,
	parameter int slave_num  = 3
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	// master side
	input  axi_bus_pkg::ax_t      m_ar [master_num],
	input  logic [master_num-1:0] m_arvalid,
	output logic [master_num-1:0] m_arready,
	output axi_bus_pkg::r_t       m_r [master_num],
	output logic [master_num-1:0] m_rvalid,
	input  logic [master_num-1:0] m_rready,
	input  axi_bus_pkg::ax_t      m_aw [master_num],
	input  logic [master_num-1:0] m_awvalid,
	output logic [master_num-1:0] m_awready,
	input  axi_bus_pkg::w_t       m_w [master_num],
	input  logic [master_num-1:0] m_wvalid,
	output logic [master_num-1:0] m_wready,
	output axi_bus_pkg::b_t       m_b [master_num],
	output logic [master_num-1:0] m_bvalid,
	input  logic [master_num-1:0] m_bready,
	// slave side
	output axi_bus_pkg::ax_t      s_ar [slave_num],
	output logic [slave_num-1:0]  s_arvalid,
	input  logic [slave_num-1:0]  s_arready,
	input  axi_bus_pkg::r_t       s_r [slave_num],
	input  logic [slave_num-1:0]  s_rvalid,
	output logic [slave_num-1:0]  s_rready,
	output axi_bus_pkg::ax_t      s_aw [slave_num],
	output logic [slave_num-1:0]  s_awvalid,
	input  logic [slave_num-1:0]  s_awready,
	output axi_bus_pkg::w_t       s_w [slave_num],
	output logic [slave_num-1:0]  s_wvalid,
	input  logic [slave_num-1:0]  s_wready,
	input  axi_bus_pkg::b_t       s_b [slave_num],
	input  logic [slave_num-1:0]  s_bvalid,
	output logic [slave_num-1:0]  s_bready
);

	axi_read_path #(
		.master_num(master_num),
		.slave_num (slave_num)
	) u_rd (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.m_ar     (m_ar),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_r      (m_r),
		.m_rvalid (m_rvalid),
		.m_rready (m_rready),
		.s_ar     (s_ar),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_r      (s_r),
		.s_rvalid (s_rvalid),
		.s_rready (s_rready)
	);

	// runs independently of the read side
	axi_write_path #(
		.master_num(master_num),
		.slave_num (slave_num)
	) u_wr (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.m_aw     (m_aw),
		.m_awvalid(m_awvalid),
		.m_awready(m_awready),
		.m_w      (m_w),
		.m_wvalid (m_wvalid),
		.m_wready (m_wready),
		.m_b      (m_b),
		.m_bvalid (m_bvalid),
		.m_bready (m_bready),
		.s_aw     (s_aw),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_w      (s_w),
		.s_wvalid (s_wvalid),
		.s_wready (s_wready),
		.s_b      (s_b),
		.s_bvalid (s_bvalid),
		.s_bready (s_bready)
	);

endmodule

/* hw/axi_bus_pkg.sv */
package axi_bus_pkg;

	localparam int id_w    = 4;
	localparam int addr_w  = 32;
	localparam int data_w  = 32;
	localparam int strb_w  = data_w / 8;
	localparam int len_w   = 8;
	localparam int size_w  = 3;
	localparam int burst_w = 2;
	localparam int resp_w  = 2;

	localparam int slave_sel_lsb = 28; // slave index lives in addr[31:28]

	// widest request vector the arbiter handles
	localparam int req_w = 16;

	typedef logic [req_w-1:0] req_vec_t;

	// shared by AR and AW
	typedef struct packed {
		logic [id_w-1:0]    id;
		logic [addr_w-1:0]  addr;
		logic [len_w-1:0]   len;
		logic [size_w-1:0]  size;
		logic [burst_w-1:0] burst;
	} ax_t;

	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [data_w-1:0] data;
		logic [resp_w-1:0] resp;
		logic              last;
	} r_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
		logic              last;
	} w_t;

	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [resp_w-1:0] resp;
	} b_t;

	// fixed priority, lowest index wins
	function automatic req_vec_t grant_lowest(input req_vec_t req);
		req_vec_t neg;
		neg = ~req + req_vec_t'(1); // two's complement isolates the lowest set bit
		return req & neg;
	endfunction

endpackage

/* hw/axi_read_path.sv */
`timescale 1ns/10ps

module axi_read_path #(
	parameter int master_num = 2,
	parameter int slave_num  = 3
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	input  axi_bus_pkg::ax_t      m_ar [master_num],
	input  logic [master_num-1:0] m_arvalid,
	output logic [master_num-1:0] m_arready,
	output axi_bus_pkg::r_t       m_r [master_num],
	output logic [master_num-1:0] m_rvalid,
	input  logic [master_num-1:0] m_rready,
	output axi_bus_pkg::ax_t      s_ar [slave_num],
	output logic [slave_num-1:0]  s_arvalid,
	input  logic [slave_num-1:0]  s_arready,
	input  axi_bus_pkg::r_t       s_r [slave_num],
	input  logic [slave_num-1:0]  s_rvalid,
	output logic [slave_num-1:0]  s_rready
);

	typedef enum logic [1:0] {
		st_idle,
		st_ar,
		st_r
	} state_e;

	state_e state;
	state_e state_nxt;

	axi_bus_pkg::req_vec_t req_vec;
	axi_bus_pkg::req_vec_t grant_vec;
	logic [master_num-1:0] grant;
	logic [axi_bus_pkg::addr_w-1:0] grant_addr;
	logic [slave_num-1:0] dec_sel;

	logic [master_num-1:0] mst_sel; // latched at grant
	logic [slave_num-1:0]  slv_sel;

	axi_bus_pkg::ax_t ar_mux;
	logic             arvalid_mux;
	logic             rready_mux;
	logic             arready_mux;
	axi_bus_pkg::r_t  r_mux;
	logic             rvalid_mux;

	logic in_ar;
	logic in_r;

	always_comb begin
		req_vec = '0;
		req_vec[master_num-1:0] = m_arvalid;
	end

	assign grant_vec = axi_bus_pkg::grant_lowest(req_vec);
	assign grant     = grant_vec[master_num-1:0];

	always_comb begin
		grant_addr = '0;
		for (int i = 0; i < master_num; i++) begin
			if (grant[i])
				grant_addr = m_ar[i].addr;
		end
	end

	addr_decoder #(
		.slave_num(slave_num)
	) u_dec (
		.addr(grant_addr),
		.sel (dec_sel)
	);

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state   <= st_idle;
			mst_sel <= '0;
			slv_sel <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_idle && |grant) begin
				mst_sel <= grant;
				slv_sel <= dec_sel;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (|grant) state_nxt = st_ar;
			st_ar:   if (arvalid_mux && arready_mux) state_nxt = st_r;
			st_r:    if (rvalid_mux && rready_mux && r_mux.last) state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	assign in_ar = (state == st_ar);
	assign in_r  = (state == st_r);

	always_comb begin
		ar_mux      = '0;
		arvalid_mux = 1'b0;
		rready_mux  = 1'b0;
		for (int i = 0; i < master_num; i++) begin
			if (mst_sel[i]) begin
				ar_mux      = m_ar[i];
				arvalid_mux = m_arvalid[i];
				rready_mux  = m_rready[i];
			end
		end
	end

	always_comb begin
		arready_mux = 1'b0;
		r_mux       = '0;
		rvalid_mux  = 1'b0;
		for (int j = 0; j < slave_num; j++) begin
			if (slv_sel[j]) begin
				arready_mux = s_arready[j];
				r_mux       = s_r[j];
				rvalid_mux  = s_rvalid[j];
			end
		end
	end

	// only the latched pair sees anything, and only in its phase
	always_comb begin
		for (int i = 0; i < master_num; i++) begin
			m_arready[i] = mst_sel[i] && in_ar && arready_mux;
			m_rvalid[i]  = mst_sel[i] && in_r && rvalid_mux;
			m_r[i]       = (mst_sel[i] && in_r) ? r_mux : '0;
		end
		for (int j = 0; j < slave_num; j++) begin
			s_arvalid[j] = slv_sel[j] && in_ar && arvalid_mux;
			s_ar[j]      = (slv_sel[j] && in_ar) ? ar_mux : '0;
			s_rready[j]  = slv_sel[j] && in_r && rready_mux;
		end
	end

endmodule

/* hw/axi_write_path.sv */
`timescale 1ns/10ps

module axi_write_path #(
	parameter int master_num = 2,
	parameter int slave_num  = 3
) (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	input  axi_bus_pkg::ax_t      m_aw [master_num],
	input  logic [master_num-1:0] m_awvalid,
	output logic [master_num-1:0] m_awready,
	input  axi_bus_pkg::w_t       m_w [master_num],
	input  logic [master_num-1:0] m_wvalid,
	output logic [master_num-1:0] m_wready,
	output axi_bus_pkg::b_t       m_b [master_num],
	output logic [master_num-1:0] m_bvalid,
	input  logic [master_num-1:0] m_bready,
	output axi_bus_pkg::ax_t      s_aw [slave_num],
	output logic [slave_num-1:0]  s_awvalid,
	input  logic [slave_num-1:0]  s_awready,
	output axi_bus_pkg::w_t       s_w [slave_num],
	output logic [slave_num-1:0]  s_wvalid,
	input  logic [slave_num-1:0]  s_wready,
	input  axi_bus_pkg::b_t       s_b [slave_num],
	input  logic [slave_num-1:0]  s_bvalid,
	output logic [slave_num-1:0]  s_bready
);

	typedef enum logic [1:0] {
		st_idle,
		st_aw,
		st_w,
		st_b
	} state_e;

	state_e state;
	state_e state_nxt;

	axi_bus_pkg::req_vec_t req_vec;
	axi_bus_pkg::req_vec_t grant_vec;
	logic [master_num-1:0] grant;
	logic [axi_bus_pkg::addr_w-1:0] grant_addr;
	logic [slave_num-1:0] dec_sel;

	logic [master_num-1:0] mst_sel;
	logic [slave_num-1:0]  slv_sel;

	// granted master side
	axi_bus_pkg::ax_t aw_mux;
	logic             awvalid_mux;
	axi_bus_pkg::w_t  w_mux;
	logic             wvalid_mux;
	logic             bready_mux;

	// selected slave side
	logic             awready_mux;
	logic             wready_mux;
	axi_bus_pkg::b_t  b_mux;
	logic             bvalid_mux;

	logic in_aw;
	logic in_w;
	logic in_b;

	always_comb begin
		req_vec = '0;
		req_vec[master_num-1:0] = m_awvalid;
	end

	assign grant_vec = axi_bus_pkg::grant_lowest(req_vec);
	assign grant     = grant_vec[master_num-1:0];

	always_comb begin
		grant_addr = '0;
		for (int i = 0; i < master_num; i++) begin
			if (grant[i])
				grant_addr = m_aw[i].addr;
		end
	end

	addr_decoder #(
		.slave_num(slave_num)
	) u_dec (
		.addr(grant_addr),
		.sel (dec_sel)
	);

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state   <= st_idle;
			mst_sel <= '0;
			slv_sel <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_idle && |grant) begin
				mst_sel <= grant;
				slv_sel <= dec_sel;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (|grant) state_nxt = st_aw;
			st_aw:   if (awvalid_mux && awready_mux) state_nxt = st_w;
			st_w:    if (wvalid_mux && wready_mux && w_mux.last) state_nxt = st_b;
			st_b:    if (bvalid_mux && bready_mux) state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	assign in_aw = (state == st_aw);
	assign in_w  = (state == st_w);
	assign in_b  = (state == st_b);

	always_comb begin
		aw_mux      = '0;
		awvalid_mux = 1'b0;
		w_mux       = '0;
		wvalid_mux  = 1'b0;
		bready_mux  = 1'b0;
		for (int i = 0; i < master_num; i++) begin
			if (mst_sel[i]) begin
				aw_mux      = m_aw[i];
				awvalid_mux = m_awvalid[i];
				w_mux       = m_w[i];
				wvalid_mux  = m_wvalid[i];
				bready_mux  = m_bready[i];
			end
		end
	end

	always_comb begin
		awready_mux = 1'b0;
		wready_mux  = 1'b0;
		b_mux       = '0;
		bvalid_mux  = 1'b0;
		for (int j = 0; j < slave_num; j++) begin
			if (slv_sel[j]) begin
				awready_mux = s_awready[j];
				wready_mux  = s_wready[j];
				b_mux       = s_b[j];
				bvalid_mux  = s_bvalid[j];
			end
		end
	end

	// early W data from the master waits here until the AW handshake is done
	always_comb begin
		for (int i = 0; i < master_num; i++) begin
			m_awready[i] = mst_sel[i] && in_aw && awready_mux;
			m_wready[i]  = mst_sel[i] && in_w && wready_mux;
			m_bvalid[i]  = mst_sel[i] && in_b && bvalid_mux;
			m_b[i]       = (mst_sel[i] && in_b) ? b_mux : '0;
		end
		for (int j = 0; j < slave_num; j++) begin
			s_awvalid[j] = slv_sel[j] && in_aw && awvalid_mux;
			s_aw[j]      = (slv_sel[j] && in_aw) ? aw_mux : '0;
			s_wvalid[j]  = slv_sel[j] && in_w && wvalid_mux;
			s_w[j]       = (slv_sel[j] && in_w) ? w_mux : '0;
			s_bready[j]  = slv_sel[j] && in_b && bready_mux;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the AXI interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_axi_bus -f axi_bus.f \
	--Mdir obj_dir -o tb_axi_bus
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_axi_bus > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
